//--- include/riscv_mul_consts.svh
`ifndef RISCV_MUL_CONSTS_SVH
`define RISCV_MUL_CONSTS_SVH

// ******************************
// Widths
// ******************************

`define RISCV_MUL_XLEN    64
`define RISCV_MUL_OPND_W  65
`define RISCV_MUL_ACC_W   130

// One Booth step per multiplier bit
`define RISCV_MUL_STEPS   65

// ******************************
// Operation codes, bit 3 is start
// ******************************

`define RISCV_MUL_OP_MUL     4'b1100
`define RISCV_MUL_OP_MULH    4'b1101
`define RISCV_MUL_OP_MULHU   4'b1110
`define RISCV_MUL_OP_MULHSU  4'b1111
`define RISCV_MUL_OP_MULW    4'b1000

`endif

//--- rtl/riscv_mul_pkg.sv
`include "riscv_mul_consts.svh"

package riscv_mul_pkg;

  // Register value and its sign-extended form
  typedef logic [`RISCV_MUL_XLEN-1:0]   xlen_t;
  typedef logic [`RISCV_MUL_OPND_W-1:0] opnd_t;

  // High half holds the partial sum, low half the shifting multiplier
  typedef logic [`RISCV_MUL_ACC_W-1:0]  acc_t;

  // Wide enough to count the Booth steps
  typedef logic [6:0]                   step_cnt_t;

  typedef logic [3:0]                   mul_ctrl_t;

  typedef enum logic
  {
    booth_idle,
    booth_run
  } booth_state_t;

endpackage

//--- rtl/riscv_mul_operand_prep.sv
`timescale 1ns/1ps

`include "riscv_mul_consts.svh"

module riscv_mul_operand_prep
  import riscv_mul_pkg::*;
(
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  mul_ctrl_t i_op,
  output opnd_t     o_x,
  output opnd_t     o_y
);

  localparam int WORD_W = `RISCV_MUL_XLEN / 2;
  localparam int WPAD_W = `RISCV_MUL_OPND_W - WORD_W;

  opnd_t rs1_sext;
  opnd_t rs2_sext;
  opnd_t rs1_zext;
  opnd_t rs2_zext;
  opnd_t rs1_wzext;
  opnd_t rs2_wzext;

  assign rs1_sext  = {i_rs1[`RISCV_MUL_XLEN-1], i_rs1};
  assign rs2_sext  = {i_rs2[`RISCV_MUL_XLEN-1], i_rs2};
  assign rs1_zext  = {1'b0, i_rs1};
  assign rs2_zext  = {1'b0, i_rs2};

  // MULW works on the low words only, treated as unsigned
  assign rs1_wzext = {{WPAD_W{1'b0}}, i_rs1[WORD_W-1:0]};
  assign rs2_wzext = {{WPAD_W{1'b0}}, i_rs2[WORD_W-1:0]};

  // x is the multiplicand, y the multiplier
  always_comb
  begin
    case (i_op)
      `RISCV_MUL_OP_MULHU:
      begin
        o_x = rs1_zext;
        o_y = rs2_zext;
      end
      `RISCV_MUL_OP_MULHSU:
      begin
        o_x = rs1_sext;
        o_y = rs2_zext;
      end
      `RISCV_MUL_OP_MULW:
      begin
        o_x = rs1_wzext;
        o_y = rs2_wzext;
      end
      default:
      begin
        o_x = rs1_sext;
        o_y = rs2_sext;
      end
    endcase
  end

endmodule

//--- rtl/riscv_mul_booth_core.sv
`timescale 1ns/1ps

`include "riscv_mul_consts.svh"

module riscv_mul_booth_core
  import riscv_mul_pkg::*;
(
  input  logic  i_riscv_mul_clk,
  input  logic  i_riscv_mul_rst,
  input  logic  i_start,
  input  opnd_t i_x,
  input  opnd_t i_y,
  output logic  o_accept,
  output logic  o_done,
  output acc_t  o_acc
);

  localparam int        HALF_W    = `RISCV_MUL_OPND_W;
  localparam step_cnt_t LAST_STEP = step_cnt_t'(`RISCV_MUL_STEPS - 1);

  booth_state_t state;
  booth_state_t state_next;

  step_cnt_t    cnt;
  step_cnt_t    cnt_next;

  // Current multiplier bit and the one below it
  logic [1:0]   pair;
  logic [1:0]   pair_next;

  // Registered done, blocks a new accept on the valid cycle
  logic         done_q;

  opnd_t        x_q;
  acc_t         acc;
  acc_t         acc_next;
  acc_t         acc_step;
  opnd_t        hi_sum;

  // ******************************
  // Control
  // ******************************

  assign o_accept = (state == booth_idle) && i_start && !done_q;
  assign o_done   = (state == booth_run) && (cnt == LAST_STEP);
  assign o_acc    = acc_next;

  always_ff @(posedge i_riscv_mul_clk or posedge i_riscv_mul_rst)
  begin
    if (i_riscv_mul_rst)
    begin
      state  <= booth_idle;
      cnt    <= '0;
      pair   <= '0;
      done_q <= 1'b0;
    end
    else
    begin
      state  <= state_next;
      cnt    <= cnt_next;
      pair   <= pair_next;
      done_q <= o_done;
    end
  end

  always_comb
  begin
    state_next = state;
    cnt_next   = cnt;
    pair_next  = pair;
    case (state)
      booth_idle:
      begin
        if (o_accept)
        begin
          state_next = booth_run;
          cnt_next   = '0;
          // The bit below the multiplier LSB is zero
          pair_next  = {i_y[0], 1'b0};
        end
      end
      booth_run:
      begin
        cnt_next  = cnt + step_cnt_t'(1);
        // After the shift the next multiplier bit sits in bit 0
        pair_next = {acc_next[0], acc[0]};
        if (o_done)
        begin
          state_next = booth_idle;
        end
      end
      default:
      begin
        state_next = booth_idle;
      end
    endcase
  end

  // ******************************
  // Datapath
  // ******************************

  // Booth recoding: 10 subtracts, 01 adds, 00 and 11 skip
  always_comb
  begin
    case (pair)
      2'b10:   hi_sum = acc[2*HALF_W-1:HALF_W] - x_q;
      2'b01:   hi_sum = acc[2*HALF_W-1:HALF_W] + x_q;
      default: hi_sum = acc[2*HALF_W-1:HALF_W];
    endcase
  end

  assign acc_step = {hi_sum, acc[HALF_W-1:0]};

  always_comb
  begin
    acc_next = acc;
    if (state == booth_run)
    begin
      acc_next = acc_t'($signed(acc_step) >>> 1);
    end
    else if (o_accept)
    begin
      acc_next = {{HALF_W{1'b0}}, i_y};
    end
  end

  always_ff @(posedge i_riscv_mul_clk)
  begin
    acc <= acc_next;
    if (o_accept)
    begin
      x_q <= i_x;
    end
  end

endmodule

//--- rtl/riscv_mul_result_sel.sv
`timescale 1ns/1ps

`include "riscv_mul_consts.svh"

module riscv_mul_result_sel
  import riscv_mul_pkg::*;
(
  input  logic      i_riscv_mul_clk,
  input  logic      i_riscv_mul_rst,
  input  mul_ctrl_t i_op,
  input  logic      i_accept,
  input  logic      i_done,
  input  acc_t      i_acc,
  output xlen_t     o_product,
  output logic      o_valid
);

  localparam int XLEN   = `RISCV_MUL_XLEN;
  localparam int WORD_W = `RISCV_MUL_XLEN / 2;

  // Operation of the multiply in flight
  mul_ctrl_t op_q;
  xlen_t     slice;

  always_comb
  begin
    case (op_q)
      `RISCV_MUL_OP_MUL:    slice = i_acc[XLEN-1:0];
      `RISCV_MUL_OP_MULH:   slice = i_acc[2*XLEN-1:XLEN];
      `RISCV_MUL_OP_MULHU:  slice = i_acc[2*XLEN-1:XLEN];
      `RISCV_MUL_OP_MULHSU: slice = i_acc[2*XLEN-1:XLEN];
      `RISCV_MUL_OP_MULW:   slice = {{WORD_W{i_acc[WORD_W-1]}}, i_acc[WORD_W-1:0]};
      default:              slice = '0;
    endcase
  end

  always_ff @(posedge i_riscv_mul_clk or posedge i_riscv_mul_rst)
  begin
    if (i_riscv_mul_rst)
    begin
      op_q      <= '0;
      o_product <= '0;
      o_valid   <= 1'b0;
    end
    else
    begin
      o_valid <= i_done;
      if (i_accept)
      begin
        op_q <= i_op;
      end
      // Product stays put until the next result
      if (i_done)
      begin
        o_product <= slice;
      end
    end
  end

endmodule

//--- rtl/riscv_mul_unit.sv
`timescale 1ns/1ps

module riscv_mul_unit
  import riscv_mul_pkg::*;
(
  input  logic      i_riscv_mul_clk,
  input  logic      i_riscv_mul_rst,
  input  xlen_t     i_riscv_mul_rs1data,
  input  xlen_t     i_riscv_mul_rs2data,
  input  mul_ctrl_t i_riscv_mul_mulctrl,
  output xlen_t     o_riscv_mul_product,
  output logic      o_riscv_mul_valid
);

  opnd_t x;
  opnd_t y;
  logic  start;
  logic  accept;
  logic  done;
  acc_t  acc;

  // Start is the top bit of the control code
  assign start = i_riscv_mul_mulctrl[3];

  // ******************************
  // Operand extension
  // ******************************

  riscv_mul_operand_prep u_operand_prep
  (
    .i_rs1 (i_riscv_mul_rs1data),
    .i_rs2 (i_riscv_mul_rs2data),
    .i_op  (i_riscv_mul_mulctrl),
    .o_x   (x),
    .o_y   (y)
  );

  // ******************************
  // Booth iteration
  // ******************************

  riscv_mul_booth_core u_booth_core
  (
    .i_riscv_mul_clk (i_riscv_mul_clk),
    .i_riscv_mul_rst (i_riscv_mul_rst),
    .i_start         (start),
    .i_x             (x),
    .i_y             (y),
    .o_accept        (accept),
    .o_done          (done),
    .o_acc           (acc)
  );

  // ******************************
  // Result slice and valid
  // ******************************

  riscv_mul_result_sel u_result_sel
  (
    .i_riscv_mul_clk (i_riscv_mul_clk),
    .i_riscv_mul_rst (i_riscv_mul_rst),
    .i_op            (i_riscv_mul_mulctrl),
    .i_accept        (accept),
    .i_done          (done),
    .i_acc           (acc),
    .o_product       (o_riscv_mul_product),
    .o_valid         (o_riscv_mul_valid)
  );

endmodule

//--- tb/riscv_mul_tb.sv
`timescale 1ns/1ps

`include "riscv_mul_consts.svh"

module riscv_mul_tb
  import riscv_mul_pkg::*;
();

  // Accept edge to valid edge is one edge per Booth step
  localparam int LATENCY    = `RISCV_MUL_STEPS;
  // The valid cycle blocks accept so the next accept lands two edges after valid
  localparam int B2B_GAP    = LATENCY + 2;
  localparam int WAIT_LIMIT = 100;
  localparam int N_RANDOM   = 20;

  logic      clk = 1'b0;
  logic      rst;
  xlen_t     rs1;
  xlen_t     rs2;
  mul_ctrl_t mulctrl;
  xlen_t     product;
  logic      valid;

  int        cycle = 0;
  int        err_cnt = 0;
  int        err_at_start = 0;
  int        pass_tests = 0;
  int        fail_tests = 0;
  xlen_t     corners [5];

  riscv_mul_unit dut0
  (
    .i_riscv_mul_clk     (clk),
    .i_riscv_mul_rst     (rst),
    .i_riscv_mul_rs1data (rs1),
    .i_riscv_mul_rs2data (rs2),
    .i_riscv_mul_mulctrl (mulctrl),
    .o_riscv_mul_product (product),
    .o_riscv_mul_valid   (valid)
  );

  initial
  begin
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  // ******************************
  // Reference model and checks
  // ******************************

  function automatic xlen_t random_word();
    return {$urandom, $urandom};
  endfunction

  // Full 128-bit products sliced the way each operation defines its result
  function automatic xlen_t expected_product(input mul_ctrl_t op, input xlen_t a,
                                             input xlen_t b);
    logic [127:0] a_sx;
    logic [127:0] b_sx;
    logic [127:0] a_zx;
    logic [127:0] b_zx;
    logic [127:0] p;
    logic [63:0]  w;
    a_sx = {{64{a[63]}}, a};
    b_sx = {{64{b[63]}}, b};
    a_zx = {64'b0, a};
    b_zx = {64'b0, b};
    w    = {32'b0, a[31:0]} * {32'b0, b[31:0]};
    case (op)
      `RISCV_MUL_OP_MUL:    p = a_sx * b_sx;
      `RISCV_MUL_OP_MULH:   p = (a_sx * b_sx) >> 64;
      `RISCV_MUL_OP_MULHU:  p = (a_zx * b_zx) >> 64;
      `RISCV_MUL_OP_MULHSU: p = (a_sx * b_zx) >> 64;
      `RISCV_MUL_OP_MULW:   p = {64'b0, {32{w[31]}}, w[31:0]};
      default:              p = '0;
    endcase
    return p[63:0];
  endfunction

  task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
    assert (act === exp)
    else
    begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input string name, input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("error in %s: %s", name, what);
      err_cnt++;
    end
  endtask

  task automatic start_test();
    err_at_start = err_cnt;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == err_at_start)
    begin
      pass_tests++;
      $display("test %s ok", name);
    end
    else
    begin
      fail_tests++;
      $display("test %s failed with %0d errors", name, err_cnt - err_at_start);
    end
  endtask

  // Samples valid on falling edges and may scramble the inputs while the core runs
  task automatic wait_valid(input string name, input logic scramble, output int at_cycle,
                            output logic seen);
    int n;
    seen     = 1'b0;
    at_cycle = 0;
    n        = 0;
    while (!seen && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
      if (valid === 1'b1)
      begin
        seen     = 1'b1;
        at_cycle = cycle;
      end
      else if (scramble && n < 40)
      begin
        rs1     = random_word();
        rs2     = random_word();
        mulctrl = mul_ctrl_t'($urandom);
      end
      else if (scramble)
      begin
        mulctrl = 4'b0000;
      end
    end
    check_cond(name, seen, "valid did not rise within 100 cycles");
  endtask

  task automatic run_op(input string name, input mul_ctrl_t op, input xlen_t a,
                        input xlen_t b, input logic scramble);
    xlen_t exp;
    int    accept_cycle;
    int    valid_cycle;
    logic  seen;
    exp = expected_product(op, a, b);
    @(negedge clk);
    rs1          = a;
    rs2          = b;
    mulctrl      = op;
    accept_cycle = cycle + 1;
    @(negedge clk);
    mulctrl = 4'b0000;
    wait_valid(name, scramble, valid_cycle, seen);
    if (seen)
    begin
      check_value(name, exp, product);
      check_cond(name, valid_cycle - accept_cycle == LATENCY,
                 "valid did not come 65 cycles after accept");
      @(negedge clk);
      check_cond(name, valid === 1'b0, "valid lasted more than one cycle");
    end
  endtask

  task automatic run_op_set(input string name, input mul_ctrl_t op);
    start_test();
    for (int i = 0; i < 5; i++)
    begin
      for (int j = 0; j < 5; j++)
      begin
        run_op(name, op, corners[i], corners[j], 1'b0);
      end
    end
    for (int k = 0; k < N_RANDOM; k++)
    begin
      run_op(name, op, random_word(), random_word(), 1'b0);
    end
    finish_test(name);
  endtask

  // Start stays high over two operations with different operands and codes
  task automatic back_to_back();
    xlen_t a1;
    xlen_t b1;
    xlen_t a2;
    xlen_t b2;
    int    v1;
    int    v2;
    logic  seen1;
    logic  seen2;
    a1 = random_word();
    b1 = random_word();
    a2 = random_word();
    b2 = random_word();
    start_test();
    @(negedge clk);
    rs1     = a1;
    rs2     = b1;
    mulctrl = `RISCV_MUL_OP_MUL;
    @(negedge clk);
    rs1     = a2;
    rs2     = b2;
    mulctrl = `RISCV_MUL_OP_MULHSU;
    wait_valid("back_to_back first", 1'b0, v1, seen1);
    if (seen1)
    begin
      check_value("back_to_back first", expected_product(`RISCV_MUL_OP_MUL, a1, b1), product);
      // The second accept has happened by the second falling edge after valid
      repeat (2) @(negedge clk);
      rs1     = random_word();
      rs2     = random_word();
      mulctrl = 4'b0000;
      wait_valid("back_to_back second", 1'b0, v2, seen2);
      if (seen2)
      begin
        check_value("back_to_back second",
                    expected_product(`RISCV_MUL_OP_MULHSU, a2, b2), product);
        check_cond("back_to_back", v2 - v1 == B2B_GAP, "valid pulses not 67 cycles apart");
      end
    end
    mulctrl = 4'b0000;
    finish_test("back_to_back");
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial
  begin
    rst     = 1'b1;
    rs1     = '0;
    rs2     = '0;
    mulctrl = '0;
    void'($urandom(32'h4dd2472e));
    corners[0] = 64'h0000_0000_0000_0000;
    corners[1] = 64'h0000_0000_0000_0001;
    corners[2] = 64'hffff_ffff_ffff_ffff;
    corners[3] = 64'h8000_0000_0000_0000;
    corners[4] = 64'h7fff_ffff_ffff_ffff;

    start_test();
    repeat (2)
    begin
      @(negedge clk);
      check_cond("reset_idle", valid === 1'b0 && product === '0,
                 "outputs not cleared during reset");
    end
    rst = 1'b0;
    // Bit 3 low must never start an operation
    repeat (100)
    begin
      @(negedge clk);
      check_cond("reset_idle", valid === 1'b0 && product === '0,
                 "valid rose or product changed without start");
      rs1     = random_word();
      rs2     = random_word();
      mulctrl = {1'b0, 3'($urandom)};
    end
    mulctrl = 4'b0000;
    finish_test("reset_idle");

    run_op_set("mul", `RISCV_MUL_OP_MUL);
    run_op_set("mulh", `RISCV_MUL_OP_MULH);
    run_op_set("mulhu", `RISCV_MUL_OP_MULHU);
    run_op_set("mulhsu", `RISCV_MUL_OP_MULHSU);
    run_op_set("mulw", `RISCV_MUL_OP_MULW);

    start_test();
    run_op("timing_hold", `RISCV_MUL_OP_MUL, random_word(), random_word(), 1'b1);
    run_op("timing_hold", `RISCV_MUL_OP_MULH, corners[3], corners[2], 1'b1);
    run_op("timing_hold", `RISCV_MUL_OP_MULHSU, random_word(), random_word(), 1'b1);
    run_op("timing_hold", `RISCV_MUL_OP_MULW, random_word(), random_word(), 1'b1);
    finish_test("timing_hold");

    back_to_back();

    $display("tests passed %0d failed %0d, failed checks %0d",
             pass_tests, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
rtl/riscv_mul_pkg.sv
rtl/riscv_mul_operand_prep.sv
rtl/riscv_mul_booth_core.sv
rtl/riscv_mul_result_sel.sv
rtl/riscv_mul_unit.sv
tb/riscv_mul_tb.sv

//--- Makefile
RTL_FILES := rtl/riscv_mul_pkg.sv rtl/riscv_mul_operand_prep.sv \
             rtl/riscv_mul_booth_core.sv rtl/riscv_mul_result_sel.sv \
             rtl/riscv_mul_unit.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module riscv_mul_tb -Mdir obj_dir

run: build
	./obj_dir/Vriscv_mul_tb | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only +incdir+include $(RTL_FILES) --top-module riscv_mul_unit

clean:
	rm -rf obj_dir sim.log
